//--- Bender.yml
package:
  name: obj_engine

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - obj_types_pkg.sv
      - obj_mem_pkg.sv
      - obj_mem_arb.sv
      - obj_scan.sv
      - obj_draw.sv
      - obj_line_buf.sv
      - obj_engine.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_obj_engine.sv

//--- build.f
+incdir+.
obj_types_pkg.sv
obj_mem_pkg.sv
obj_mem_arb.sv
obj_scan.sv
obj_draw.sv
obj_line_buf.sv
obj_engine.sv
tb_obj_engine.sv

//--- obj_draw.sv
// queues draw commands and paints one 16-pixel sprite row at a time
// two memory words per row, nibble-packed, lowest nibble is the leftmost pixel
// old-wins: a pixel is written only over a transparent one
// hs flushes the queue and abandons the sprite in progress
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_draw (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hs,
    input  logic                     cmd_valid,
    input  obj_types_pkg::draw_cmd_t cmd,
    output logic                     credit,
    output obj_mem_pkg::mem_req_t    mem_req,
    input  obj_mem_pkg::mem_rsp_t    mem_rsp,
    output logic                     wr_en,
    output logic [`BUF_AW-1:0]       wr_addr,
    output obj_types_pkg::pixel_t    wr_data,
    input  obj_types_pkg::pixel_t    old_data
);
    import obj_types_pkg::*;

    localparam int QW = $clog2(`CMD_DEPTH);
    localparam int CW = $clog2(`CMD_DEPTH + 1);

    draw_cmd_t          q [`CMD_DEPTH];
    logic [QW-1:0]      wp;
    logic [QW-1:0]      rp;
    logic [CW-1:0]      cnt;
    logic               push;
    logic               pop;
    draw_state_e        st;
    draw_cmd_t          w;          // command being drawn
    logic [63:0]        gfx;        // whole row, pixel i at bits 4i
    logic [3:0]         step;
    logic [3:0]         pix;
    logic [3:0]         nib;
    logic               drop;       // stale read left over from before hs
    logic [`MEM_AW-1:0] row_addr;

    assign push = cmd_valid & ~hs;
    assign pop  = st == DRAW_IDLE && cnt != '0 && !hs;

    // base + code*32 + row*2 + half
    assign row_addr = `GFX_BASE + `MEM_AW'({w.code, w.row, st == DRAW_FETCH1});

    assign pix     = w.hflip ? 4'd15 - step : step;
    assign nib     = gfx[{pix, 2'b00} +: 4];
    assign wr_addr = w.x + `BUF_AW'(step);    // wraps at 512
    assign wr_data = '{pal: w.pal, color: nib};
    assign wr_en   = st == DRAW_PAINT && nib != 4'd0 && old_data.color == 4'd0 && !hs;

    always_ff @(posedge clk) begin
        if (push) q[wp] <= cmd;
    end

    always_ff @(posedge clk) begin
        if (rst || hs) begin
            wp  <= '0;
            rp  <= '0;
            cnt <= '0;
        end else begin
            if (push) wp <= wp + QW'(1);
            if (pop) rp <= rp + QW'(1);
            cnt <= cnt + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= DRAW_IDLE;
            mem_req <= '0;
            drop    <= 1'b0;
            credit  <= 1'b0;
            step    <= '0;
        end else begin
            credit <= pop;  // one credit per popped command
            if (mem_rsp.ok) begin
                mem_req.cs <= 1'b0;
                drop       <= 1'b0;
            end
            if (hs) begin
                st   <= DRAW_IDLE;
                drop <= mem_req.cs & ~mem_rsp.ok;
            end else begin
                case (st)
                    DRAW_IDLE: begin
                        if (pop) begin
                            w  <= q[rp];    // latched, the queue slot is free again
                            st <= DRAW_FETCH0;
                        end
                    end
                    DRAW_FETCH0, DRAW_FETCH1: begin
                        if (!mem_req.cs) begin
                            mem_req.cs   <= 1'b1;
                            mem_req.addr <= row_addr;
                        end else if (mem_rsp.ok && !drop) begin
                            if (st == DRAW_FETCH0) begin
                                gfx[31:0] <= mem_rsp.data;   // pixels 0-7
                                st        <= DRAW_FETCH1;
                            end else begin
                                gfx[63:32] <= mem_rsp.data;  // pixels 8-15
                                step       <= '0;
                                st         <= DRAW_PAINT;
                            end
                        end
                    end
                    DRAW_PAINT: begin
                        step <= step + 4'd1;
                        if (step == 4'd15) st <= DRAW_IDLE;
                    end
                    default: st <= DRAW_IDLE;
                endcase
            end
        end
    end

    // scanner credits keep the queue from filling past its depth
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> cnt < CW'(`CMD_DEPTH));

endmodule

//--- obj_engine.sv
// scanline sprite engine top
// line prepared after an hs shows on pxl after the following hs
// one external memory port holds both the object table and the graphics
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hs,
    input  logic [7:0]            line,
    input  logic                  pxl_cen,
    input  logic [`BUF_AW-1:0]    hdump,
    output obj_mem_pkg::mem_req_t mem_req,
    input  obj_mem_pkg::mem_rsp_t mem_rsp,
    output obj_types_pkg::pixel_t pxl
);
    import obj_types_pkg::*;
    import obj_mem_pkg::*;

    mem_req_t           scan_req;
    mem_rsp_t           scan_rsp;
    mem_req_t           draw_req;
    mem_rsp_t           draw_rsp;
    logic               cmd_valid;
    draw_cmd_t          cmd;
    logic               credit;
    logic               wr_en;
    logic [`BUF_AW-1:0] wr_addr;
    pixel_t             wr_data;
    pixel_t             old_data;

    obj_scan u_scan (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hs        ( hs        ),
        .line      ( line      ),
        .mem_req   ( scan_req  ),
        .mem_rsp   ( scan_rsp  ),
        .cmd_valid ( cmd_valid ),
        .cmd       ( cmd       ),
        .credit    ( credit    )
    );

    obj_draw u_draw (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .hs        ( hs        ),
        .cmd_valid ( cmd_valid ),
        .cmd       ( cmd       ),
        .credit    ( credit    ),
        .mem_req   ( draw_req  ),
        .mem_rsp   ( draw_rsp  ),
        .wr_en     ( wr_en     ),
        .wr_addr   ( wr_addr   ),
        .wr_data   ( wr_data   ),
        .old_data  ( old_data  )
    );

    obj_mem_arb u_arb (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .scan_req ( scan_req ),
        .draw_req ( draw_req ),
        .scan_rsp ( scan_rsp ),
        .draw_rsp ( draw_rsp ),
        .mem_req  ( mem_req  ),
        .mem_rsp  ( mem_rsp  )
    );

    obj_line_buf u_line_buf (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hs       ( hs       ),
        .wr_en    ( wr_en    ),
        .wr_addr  ( wr_addr  ),
        .wr_data  ( wr_data  ),
        .old_data ( old_data ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .pxl      ( pxl      )
    );

endmodule

//--- obj_line_buf.sv
// double line buffer, halves swap on the rising edge of hs
// write side has a combinational read-back for the priority check
// display side reads on pxl_cen and clears what it read
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_line_buf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hs,
    input  logic                  wr_en,
    input  logic [`BUF_AW-1:0]    wr_addr,
    input  obj_types_pkg::pixel_t wr_data,
    output obj_types_pkg::pixel_t old_data,
    input  logic                  pxl_cen,
    input  logic [`BUF_AW-1:0]    hdump,
    output obj_types_pkg::pixel_t pxl
);
    import obj_types_pkg::*;

    localparam int DEPTH = 1 << `BUF_AW;

    // both halves start transparent
    pixel_t half0 [DEPTH] = '{default: '0};
    pixel_t half1 [DEPTH] = '{default: '0};
    logic   bank;       // half being drawn, the other one is shown
    logic   hs_q;
    pixel_t rd_data;

    assign old_data = bank ? half1[wr_addr] : half0[wr_addr];
    assign rd_data  = bank ? half0[hdump] : half1[hdump];

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= 1'b0;
            hs_q <= 1'b0;
        end else begin
            hs_q <= hs;
            if (hs && !hs_q) bank <= ~bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= rd_data;     // holds between enables
        end
    end

    // draw into one half, clear behind the readout in the other
    always_ff @(posedge clk) begin
        if (bank) begin
            if (wr_en) half1[wr_addr] <= wr_data;
            if (pxl_cen) half0[hdump] <= '0;
        end else begin
            if (wr_en) half0[wr_addr] <= wr_data;
            if (pxl_cen) half1[hdump] <= '0;
        end
    end

endmodule

//--- obj_mem_arb.sv
// round-robin share of one memory port between scanner and drawer
// a request is forwarded in the cycle it is granted, owner held until ok
// peers must drop cs the cycle after their ok
`timescale 1ns/1ps

module obj_mem_arb (
    input  logic                  clk,
    input  logic                  rst,
    input  obj_mem_pkg::mem_req_t scan_req,
    input  obj_mem_pkg::mem_req_t draw_req,
    output obj_mem_pkg::mem_rsp_t scan_rsp,
    output obj_mem_pkg::mem_rsp_t draw_rsp,
    output obj_mem_pkg::mem_req_t mem_req,
    input  obj_mem_pkg::mem_rsp_t mem_rsp
);
    import obj_mem_pkg::*;

    mem_port_e owner;       // valid while busy
    mem_port_e pick;        // candidate when idle
    mem_port_e sel;         // peer connected right now
    logic      busy;
    logic      last_draw;   // drawer was served last
    logic      any_req;

    assign any_req = scan_req.cs | draw_req.cs;

    always_comb begin
        if (scan_req.cs && draw_req.cs) begin
            pick = last_draw ? PORT_SCAN : PORT_DRAW;   // the one not served last
        end else if (draw_req.cs) begin
            pick = PORT_DRAW;
        end else begin
            pick = PORT_SCAN;
        end
    end

    assign sel     = busy ? owner : pick;
    assign mem_req = (sel == PORT_DRAW) ? draw_req : scan_req;

    // data fans out, ok only to the connected peer
    assign scan_rsp = '{ok: mem_rsp.ok && sel == PORT_SCAN, data: mem_rsp.data};
    assign draw_rsp = '{ok: mem_rsp.ok && sel == PORT_DRAW, data: mem_rsp.data};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            owner     <= PORT_SCAN;
            last_draw <= 1'b0;
        end else begin
            if (mem_rsp.ok) begin
                busy <= 1'b0;   // release, next grant may follow at once
            end else if (!busy && any_req) begin
                busy  <= 1'b1;
                owner <= pick;
            end
            if (!busy && any_req) last_draw <= (pick == PORT_DRAW);
        end
    end

    // the owner keeps cs up with the same addr until its ok
    a_owner_holds: assert property (@(posedge clk) disable iff (rst)
        busy |-> mem_req.cs && $stable(mem_req.addr));

    // memory only answers an access that is still being requested
    a_ok_live: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ok |-> mem_req.cs);

endmodule

//--- obj_mem_pkg.sv
// shared memory port types
// cs holds with a stable addr until ok pulses, one access in flight
`include "obj_settings.svh"

package obj_mem_pkg;

    typedef struct packed {
        logic               cs;
        logic [`MEM_AW-1:0] addr;   // word address
    } mem_req_t;

    typedef struct packed {
        logic        ok;    // one-cycle pulse, data valid with it
        logic [31:0] data;
    } mem_rsp_t;

    // who owns the memory port
    typedef enum logic {
        PORT_SCAN,
        PORT_DRAW
    } mem_port_e;

endpackage

//--- obj_scan.sv
// walks the object table once per line and sends hits to the drawer
// an entry hits when target line minus y, mod 256, is below 16
// sends only with credit, credits reload to CMD_DEPTH at hs
`timescale 1ns/1ps
`include "obj_settings.svh"

module obj_scan (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hs,
    input  logic [7:0]               line,
    output obj_mem_pkg::mem_req_t    mem_req,
    input  obj_mem_pkg::mem_rsp_t    mem_rsp,
    output logic                     cmd_valid,
    output obj_types_pkg::draw_cmd_t cmd,
    input  logic                     credit
);
    import obj_types_pkg::*;

    localparam int IW   = $clog2(`OBJ_COUNT);
    localparam int CNTW = $clog2(`CMD_DEPTH + 1);

    scan_state_e     st;
    logic [IW-1:0]   idx;       // table entry being looked at
    logic [7:0]      target;    // line being prepared
    obj_attr_t       attr;
    logic [CNTW-1:0] credits;
    logic            drop;      // in-flight read from before hs, ignore its data
    logic [7:0]      dy;
    logic            hit;
    logic            last;
    logic            send;

    assign dy   = target - attr.y;      // wraps past 255 on purpose
    assign hit  = dy < 8'd16;
    assign last = idx == IW'(`OBJ_COUNT - 1);
    assign send = st == SCAN_SEND && credits != '0 && !hs;

    // send and credit in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (rst || hs) begin
            credits <= CNTW'(`CMD_DEPTH);   // drawer queue is emptied at hs
        end else begin
            credits <= credits + CNTW'(credit) - CNTW'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= SCAN_IDLE;
            idx       <= '0;
            target    <= '0;
            drop      <= 1'b0;
            mem_req   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (mem_rsp.ok) begin
                mem_req.cs <= 1'b0;
                drop       <= 1'b0;
            end
            if (hs) begin
                st     <= SCAN_READ;
                idx    <= '0;
                target <= line + 8'd1;
                drop   <= mem_req.cs & ~mem_rsp.ok;    // let the old access finish
            end else begin
                case (st)
                    SCAN_READ: begin
                        if (!mem_req.cs) begin
                            mem_req.cs   <= 1'b1;
                            mem_req.addr <= `MEM_AW'(idx);
                        end else if (mem_rsp.ok && !drop) begin
                            attr <= obj_attr_t'(mem_rsp.data);
                            st   <= SCAN_CHECK;
                        end
                    end
                    SCAN_CHECK: begin
                        if (hit) begin
                            st <= SCAN_SEND;
                        end else if (last) begin
                            st <= SCAN_DONE;
                        end else begin
                            idx <= idx + IW'(1);
                            st  <= SCAN_READ;
                        end
                    end
                    SCAN_SEND: begin
                        if (send) begin   // otherwise wait for a credit
                            cmd_valid <= 1'b1;
                            cmd <= '{code: attr.code, row: dy[3:0], x: attr.x,
                                     hflip: attr.hflip, pal: attr.pal};
                            if (last) begin
                                st <= SCAN_DONE;
                            end else begin
                                idx <= idx + IW'(1);
                                st  <= SCAN_READ;
                            end
                        end
                    end
                    SCAN_IDLE, SCAN_DONE: st <= st;   // wait for hs
                    default: st <= SCAN_IDLE;
                endcase
            end
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= CNTW'(`CMD_DEPTH));

endmodule

//--- obj_settings.svh
// sizes shared by the sprite engine, built for these values only
// CMD_DEPTH must stay a power of two, the drawer queue pointers wrap on it
// graphics addresses are truncated to MEM_AW bits
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// table entries walked per line
`define OBJ_COUNT 64

// shared memory word address width
`define MEM_AW 12

// first word of the nibble-packed graphics
`define GFX_BASE 12'h100

// line buffer address, one half holds 512 pixels
`define BUF_AW 9

// drawer queue depth and scanner credit count
`define CMD_DEPTH 4

`endif

//--- obj_types_pkg.sv
// sprite table, draw command and pixel formats
// table word fields listed from the msb down, pal sits in the lsbs
package obj_types_pkg;

    // one 32-bit object table word
    typedef struct packed {
        logic [7:0] y;      // top line of the sprite
        logic [8:0] x;      // left pixel
        logic [9:0] code;   // graphics tile
        logic       hflip;
        logic [3:0] pal;
    } obj_attr_t;

    // what the scanner hands to the drawer
    typedef struct packed {
        logic [9:0] code;
        logic [3:0] row;    // line inside the 16-line sprite
        logic [8:0] x;
        logic       hflip;
        logic [3:0] pal;
    } draw_cmd_t;

    // line buffer entry, color 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] color;
    } pixel_t;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_CHECK,
        SCAN_SEND,
        SCAN_DONE
    } scan_state_e;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FETCH0,
        DRAW_FETCH1,
        DRAW_PAINT
    } draw_state_e;

endpackage

//--- tb_obj_check.svh
// compare tasks and reference line model, included inside the testbench module
// the model reads the testbench memory, so table and graphics stay put during a line
`ifndef TB_OBJ_CHECK_SVH
`define TB_OBJ_CHECK_SVH

task automatic compare_pixel(input string name, input int idx, input pixel_t got,
                             input pixel_t exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Error at %0t ns: %s got %h, expected %h (hdump %0d)",
                 $time, name, got, exp, idx);
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Error at %0t ns: %s got %b, expected %b", $time, name, got, exp);
    end
endtask

// walks the table in order, so earlier entries claim pixels first
task automatic build_line(input logic [7:0] target);
    obj_attr_t   attr;
    logic [7:0]  dy;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] word;
    logic [3:0]  color;
    int          base;
    int          p;
    int          pos;
    next_exp = '{default: '0};
    for (int e = 0; e < `OBJ_COUNT; e++) begin
        attr = obj_attr_t'(mem[e]);
        dy   = target - attr.y;            // mod 256
        if (dy < 8'd16) begin
            base = (`GFX_BASE + int'(attr.code) * 32 + int'(dy) * 2) % (1 << `MEM_AW);
            w0   = mem[base];
            w1   = mem[(base + 1) % (1 << `MEM_AW)];
            for (int i = 0; i < 16; i++) begin
                p     = attr.hflip ? 15 - i : i;
                word  = (p < 8) ? w0 : w1;
                color = word[4 * (p % 8) +: 4];
                pos   = (int'(attr.x) + i) % LINE_W;
                if (color != 4'd0 && next_exp[pos].color == 4'd0) begin
                    next_exp[pos] = '{pal: attr.pal, color: color};
                end
            end
        end
    end
endtask

`endif

//--- tb_obj_engine.sv
// directed testbench for the sprite engine, checks every readout against a line model
// memory answers 1 to 3 cycles after cs, inputs change 1 ns after the rising edge
// each line period is LINE_CYCLES long, table and graphics change only between periods
`timescale 1ns/1ps
`include "obj_settings.svh"

module tb_obj_engine;
    import obj_types_pkg::*;
    import obj_mem_pkg::*;

    localparam int LINE_CYCLES = 1500;
    localparam int NUM_TESTS   = 5;
    localparam int LINE_W      = 1 << `BUF_AW;
    localparam int CLK_NS      = 4;

    logic               clk;
    logic               rst;
    logic               hs;
    logic [7:0]         line;
    logic               pxl_cen;
    logic [`BUF_AW-1:0] hdump;
    mem_req_t           mem_req;
    mem_rsp_t           mem_rsp;
    pixel_t             pxl;

    logic [31:0] mem [1 << `MEM_AW];  // object table at 0, graphics from GFX_BASE
    pixel_t      cur_exp  [LINE_W];   // expected content of the half being shown
    pixel_t      next_exp [LINE_W];   // expected content of the half being drawn
    int          err_count;
    int          check_count;
    int          pass_count;

    `include "tb_obj_check.svh"

    obj_engine u_dut (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .hs      ( hs      ),
        .line    ( line    ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .mem_req ( mem_req ),
        .mem_rsp ( mem_rsp ),
        .pxl     ( pxl     )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // four line periods per test, no test uses more than three
    initial begin
        #(NUM_TESTS * 4 * LINE_CYCLES * CLK_NS);
        $display("timeout: the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    // one access at a time, ok pulses for a cycle while cs is still up
    initial begin : mem_model
        int                 lat;
        logic               busy;
        logic [`MEM_AW-1:0] addr_q;
        void'($urandom(32'h022c_a159));  // latency sequence is fixed per run
        busy    = 1'b0;
        lat     = 0;
        addr_q  = '0;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rsp.ok = 1'b0;
            if (busy) begin
                lat = lat - 1;
                if (lat == 0) begin
                    mem_rsp.ok   = 1'b1;
                    mem_rsp.data = mem[addr_q];
                    busy         = 1'b0;
                end
            end else if (mem_req.cs === 1'b1) begin
                addr_q = mem_req.addr;     // addr holds until ok
                lat    = $urandom_range(3, 1);
                busy   = 1'b1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // graphics get a pattern built from the whole address, zero nibbles included
    task automatic fill_memory();
        for (int a = 0; a < (1 << `MEM_AW); a++) begin
            mem[a] = (32'(a) * 32'h9e37_79b1) ^ (32'(a) << 16);
        end
    endtask

    task automatic set_obj(input int idx, input logic [7:0] y, input logic [8:0] x,
                           input logic [9:0] code, input logic hflip, input logic [3:0] pal);
        obj_attr_t attr;
        attr     = '{y: y, x: x, code: code, hflip: hflip, pal: pal};
        mem[idx] = attr;
    endtask

    // every entry parked on lines 200 to 215, which no test targets
    task automatic clear_table();
        for (int e = 0; e < `OBJ_COUNT; e++) begin
            set_obj(e, 8'd200, 9'(e * 8), 10'(e), e[0], e[3:0]);
        end
    endtask

    // pixel i is nibble i of pix, lowest first
    task automatic set_row(input int code, input int row, input logic [63:0] pix);
        int a;
        a          = `GFX_BASE + code * 32 + row * 2;
        mem[a]     = pix[31:0];
        mem[a + 1] = pix[63:32];
    endtask

    // one hs period: the half drawn last period is read out and checked
    task automatic run_line(input logic [7:0] line_in);
        int i;
        cur_exp = next_exp;
        build_line(line_in + 8'd1);   // scanner prepares the next line
        hs   = 1'b1;
        line = line_in;
        next_cycle();
        hs = 1'b0;
        for (i = 0; i < LINE_W; i++) begin
            pxl_cen = 1'b1;
            hdump   = `BUF_AW'(i);
            next_cycle();
            pxl_cen = 1'b0;
            compare_pixel("pxl", i, pxl, cur_exp[i]);
            next_cycle();
            compare_pixel("pxl", i, pxl, cur_exp[i]);  // held with pxl_cen low
        end
        repeat (LINE_CYCLES - 2 * LINE_W - 1) next_cycle();
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_count == err_before) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d mismatches", name, err_count - err_before);
        end
    endtask

    task automatic single_sprite();
        int err_before;
        err_before = err_count;
        clear_table();
        set_obj(5, 8'd40, 9'd60, 10'd3, 1'b0, 4'd5);
        set_row(3, 5, 64'hfedc_ba98_7654_3210);     // pixel 0 transparent
        run_line(8'd44);
        run_line(8'd100);
        report_test("single_sprite", err_before);
    endtask

    task automatic overlap_priority();
        int err_before;
        err_before = err_count;
        clear_table();
        set_obj(2, 8'd78, 9'd200, 10'd20, 1'b0, 4'd1);  // on top, every other pixel clear
        set_obj(7, 8'd80, 9'd204, 10'd21, 1'b0, 4'd2);
        set_obj(9, 8'd70, 9'd196, 10'd22, 1'b0, 4'd3);
        set_row(20, 2, 64'h0f0f_0f0f_0f0f_0f0f);
        set_row(21, 0, 64'h2222_2222_2222_2222);
        set_row(22, 10, 64'h3333_3333_3333_3333);
        run_line(8'd79);
        run_line(8'd100);
        report_test("overlap_priority", err_before);
    endtask

    task automatic flip_and_wrap();
        int err_before;
        err_before = err_count;
        clear_table();
        set_obj(0, 8'd120, 9'd100, 10'd8, 1'b1, 4'd6);
        set_obj(1, 8'd120, 9'd504, 10'd9, 1'b0, 4'd7);  // runs past 511 into 0
        set_obj(2, 8'd112, 9'd510, 10'd9, 1'b1, 4'd4);  // flipped and wrapped
        set_row(8, 0, 64'hfedc_ba98_7654_3210);
        set_row(9, 0, 64'h1234_5678_9abc_def1);
        run_line(8'd119);
        run_line(8'd100);
        report_test("flip_and_wrap", err_before);
    endtask

    // line 20 hits y 10 and 5, line 3 hits y 0 and y 250 across the wrap
    task automatic row_select();
        int err_before;
        err_before = err_count;
        clear_table();
        set_obj(0, 8'd10, 9'd30, 10'd30, 1'b0, 4'd1);
        set_obj(1, 8'd5, 9'd90, 10'd31, 1'b0, 4'd2);
        set_obj(2, 8'd4, 9'd150, 10'd32, 1'b0, 4'd3);
        set_obj(3, 8'd21, 9'd210, 10'd33, 1'b0, 4'd4);
        set_obj(4, 8'd250, 9'd270, 10'd34, 1'b0, 4'd5);
        set_obj(5, 8'd0, 9'd330, 10'd35, 1'b1, 4'd6);
        run_line(8'd19);
        run_line(8'd2);
        run_line(8'd100);
        report_test("row_select", err_before);
    endtask

    // six hits need credits back from the drawer, then an empty line
    task automatic clear_and_many();
        int err_before;
        err_before = err_count;
        clear_table();
        for (int k = 0; k < 6; k++) begin
            set_obj(10 + k * 3, 8'(150 - k), 9'(20 + k * 70), 10'(10 + k), k[0], 4'(8 + k));
        end
        run_line(8'd149);
        run_line(8'd30);   // target 31 has no hits
        run_line(8'd60);
        report_test("clear_and_many", err_before);
    endtask

    initial begin : main
        rst         = 1'b1;
        hs          = 1'b0;
        line        = '0;
        pxl_cen     = 1'b0;
        hdump       = '0;
        err_count   = 0;
        check_count = 0;
        pass_count  = 0;
        cur_exp     = '{default: '0};
        next_exp    = '{default: '0};   // both halves start transparent
        fill_memory();
        clear_table();
        repeat (5) next_cycle();
        rst = 1'b0;
        next_cycle();
        compare_bit("mem_req.cs", mem_req.cs, 1'b0);
        compare_pixel("pxl", 0, pxl, '0);

        single_sprite();
        overlap_priority();
        flip_and_wrap();
        row_select();
        clear_and_many();

        $display("%0d of %0d tests passed, %0d checks, %0d errors",
                 pass_count, NUM_TESTS, check_count, err_count);
        if (err_count == 0 && pass_count == NUM_TESTS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
